//--- common/loader_pkg.sv
// Image loader shared definitions
// Data types, download indexes, memory bases and CRT layout constants

package loader_pkg;

	// ==============================
	// Basic types
	// ==============================
	typedef logic [7:0] byte_t;
	typedef logic [24:0] load_addr_t;
	typedef logic [24:0] dl_offset_t;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_PRG,
		KIND_CRT,
		KIND_TAP
	} file_kind_e;

	// One host byte with its place in the file
	typedef struct packed {
		dl_offset_t offset;
		byte_t      data;
		file_kind_e kind;
	} dl_byte_t;

	// One external memory write
	typedef struct packed {
		load_addr_t addr;
		byte_t      data;
	} mem_wr_t;

	// CRT file header fields
	typedef struct packed {
		logic [15:0] cart_id;
		byte_t       exrom;
		byte_t       game;
	} cart_info_t;

	// CHIP packet bank record with big-endian fields in the file
	typedef struct packed {
		byte_t       bank_type;
		logic [15:0] bank_num;
		logic [15:0] bank_laddr;
		logic [15:0] bank_size;
	} bank_hdr_t;

	// ==============================
	// Download indexes
	// ==============================
	localparam byte_t IDX_PRG     = 8'd2;
	localparam byte_t IDX_CRT     = 8'd3;
	localparam byte_t IDX_CRT_ALT = 8'hC0;
	localparam byte_t IDX_TAP     = 8'd4;

	// Memory bases
	localparam load_addr_t CART_BASE = 25'h100000;
	localparam load_addr_t TAP_BASE  = 25'h200000;

	// CRT layout
	// Cart id low byte follows at CRT_ID_OFS + 1
	localparam dl_offset_t  CRT_ID_OFS      = 25'h16;
	localparam dl_offset_t  CRT_EXROM_OFS   = 25'h18;
	localparam dl_offset_t  CRT_GAME_OFS    = 25'h19;
	localparam dl_offset_t  CRT_CHIP_START  = 25'h40;
	localparam logic [31:0] CHIP_HDR_LEN    = 32'd16;
	localparam int          BANK_ALIGN_BITS = 13;

endpackage

//--- design/dl_capture.sv
// Download capture
// Registers host bytes, classifies the file and drives host back-pressure

`timescale 1ns/10ps

module dl_capture import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  byte_t      dl_index_i,
	input  logic       dl_wr_i,
	input  dl_offset_t dl_addr_i,
	input  byte_t      dl_data_i,
	input  logic       busy_i,
	output logic       dl_wait_o,
	output dl_byte_t   byte_o,
	output logic       byte_vld_o,
	output logic       dl_start_o,
	output logic       dl_end_o
);

	logic       active_q;
	logic       start_edge;
	logic       host_wr;
	file_kind_e kind_now;
	file_kind_e kind_cur;
	dl_byte_t   byte_q;
	logic       vld_q;
	logic       start_q;
	logic       end_q;
	logic       wait_q;
	logic [1:0] stage_q;

	assign start_edge = dl_active_i && !active_q;
	assign host_wr    = dl_wr_i && dl_active_i;

	always_comb begin
		case (dl_index_i)
			IDX_PRG:              kind_now = KIND_PRG;
			IDX_CRT, IDX_CRT_ALT: kind_now = KIND_CRT;
			IDX_TAP:              kind_now = KIND_TAP;
			default:              kind_now = KIND_NONE;
		endcase
	end

	// A byte in the very first active cycle takes the fresh kind
	assign kind_cur = start_edge ? kind_now : byte_q.kind;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_q <= 1'b0;
			start_q  <= 1'b0;
			end_q    <= 1'b0;
			vld_q    <= 1'b0;
			wait_q   <= 1'b0;
			stage_q  <= 2'd0;
			byte_q   <= '0;
		end else begin
			active_q <= dl_active_i;
			start_q  <= start_edge;
			end_q    <= !dl_active_i && active_q;
			vld_q    <= host_wr;
			if (start_edge)
				byte_q.kind <= kind_now;
			if (host_wr)
				byte_q <= '{offset: dl_addr_i, data: dl_data_i, kind: kind_cur};
			// Stage covers the loader and port latency until busy_i is valid
			if (host_wr)
				stage_q <= 2'd2;
			else if (stage_q != 2'd0)
				stage_q <= stage_q - 2'd1;
			wait_q <= host_wr || (stage_q != 2'd0) || busy_i;
		end
	end

	assign dl_wait_o  = wait_q;
	assign byte_o     = byte_q;
	assign byte_vld_o = vld_q;
	assign dl_start_o = start_q;
	assign dl_end_o   = end_q;

endmodule

//--- design/mem_write_port.sv
// Memory write port
// Holds one pending write and runs a four-phase req/ack handshake

`timescale 1ns/10ps

module mem_write_port import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset_n,
	input  mem_wr_t wr_i,
	input  logic    wr_vld_i,
	input  logic    mem_ack_i,
	output logic    busy_o,
	output logic    mem_req_o,
	output mem_wr_t mem_wr_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_ACK_LOW
	} port_state_e;

	port_state_e state_q;
	mem_wr_t     wr_q;

	// ==============================
	// Handshake sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (wr_vld_i)
						state_q <= ST_REQ;
				end
				// Req drops the cycle after ack is seen
				ST_REQ: begin
					if (mem_ack_i)
						state_q <= ST_ACK_LOW;
				end
				// Wait for memory to release ack
				ST_ACK_LOW: begin
					if (!mem_ack_i)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Data is only taken while idle so it holds through the handshake
	always_ff @(posedge clk_sys) begin
		if (state_q == ST_IDLE && wr_vld_i)
			wr_q <= wr_i;
	end

	assign mem_req_o = state_q == ST_REQ;
	assign busy_o    = state_q != ST_IDLE;
	assign mem_wr_o  = wr_q;

endmodule

//--- loader/chip_packet_parser.sv
// CRT CHIP packet parser
// Walks packet headers, counts payload bytes and publishes bank records

`timescale 1ns/10ps

module chip_packet_parser import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      crt_restart_i,
	input  logic      chip_byte_i,
	input  byte_t     data_i,
	output logic      payload_o,
	output logic      align_o,
	output bank_hdr_t bank_hdr_o,
	output logic      bank_hdr_wr_o
);

	logic [3:0]  hdr_cnt_q;
	logic [31:0] blk_len_q;
	logic        hdr_open;
	logic        in_hdr;
	bank_hdr_t   bank_hdr_q;
	logic        hdr_wr_q;

	// Working copy of the record until its last byte arrives
	byte_t       bank_type_q;
	logic [15:0] bank_num_q;
	logic [15:0] bank_laddr_q;
	byte_t       size_hi_q;

	// Header opens when the previous packet is fully consumed
	assign hdr_open  = chip_byte_i && (blk_len_q == '0) && (hdr_cnt_q == 4'd0);
	assign in_hdr    = chip_byte_i && (hdr_cnt_q != 4'd0);
	assign payload_o = chip_byte_i && !hdr_open && !in_hdr;
	assign align_o   = hdr_open;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt_q  <= 4'd0;
			blk_len_q  <= '0;
			bank_hdr_q <= '0;
			hdr_wr_q   <= 1'b0;
		end else begin
			hdr_wr_q <= 1'b0;
			if (crt_restart_i) begin
				hdr_cnt_q <= 4'd0;
				blk_len_q <= '0;
			end else if (hdr_open) begin
				hdr_cnt_q <= 4'd1;
			end else if (in_hdr) begin
				// Position 15 wraps the counter back to zero
				hdr_cnt_q <= hdr_cnt_q + 4'd1;
				case (hdr_cnt_q)
					4'd4: blk_len_q[31:24] <= data_i;
					4'd5: blk_len_q[23:16] <= data_i;
					4'd6: blk_len_q[15:8]  <= data_i;
					4'd7: blk_len_q[7:0]   <= data_i;
					4'd8: blk_len_q        <= blk_len_q - CHIP_HDR_LEN;
					4'd15: begin
						bank_hdr_q <= '{bank_type:  bank_type_q,
						                bank_num:   bank_num_q,
						                bank_laddr: bank_laddr_q,
						                bank_size:  {size_hi_q, data_i}};
						hdr_wr_q   <= 1'b1;
					end
					default: ;
				endcase
			end else if (payload_o) begin
				blk_len_q <= blk_len_q - 1'b1;
			end
		end
	end

	// ==============================
	// Bank record fields
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (in_hdr) begin
			case (hdr_cnt_q)
				4'd9:  bank_type_q         <= data_i;
				4'd10: bank_num_q[15:8]    <= data_i;
				4'd11: bank_num_q[7:0]     <= data_i;
				4'd12: bank_laddr_q[15:8]  <= data_i;
				4'd13: bank_laddr_q[7:0]   <= data_i;
				4'd14: size_hi_q           <= data_i;
				default: ;
			endcase
		end
	end

	assign bank_hdr_o    = bank_hdr_q;
	assign bank_hdr_wr_o = hdr_wr_q;

endmodule

//--- loader/image_loader.sv
// Image loader core
// Tracks the write address, applies PRG, TAP and CRT rules and issues writes

`timescale 1ns/10ps

module image_loader import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  dl_byte_t   byte_i,
	input  logic       byte_vld_i,
	input  logic       dl_start_i,
	input  logic       dl_end_i,
	output mem_wr_t    wr_o,
	output logic       wr_vld_o,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o,
	output bank_hdr_t  bank_hdr_o,
	output logic       bank_hdr_wr_o
);

	load_addr_t addr_q;
	load_addr_t eff_addr;
	load_addr_t addr_rounded;
	mem_wr_t    wr_q;
	logic       wr_vld_q;
	cart_info_t cart_info_q;
	logic       attached_q;
	logic       is_prg;
	logic       is_tap;
	logic       is_crt;
	logic       ofs_zero;
	logic       prg_hdr;
	logic       crt_restart;
	logic       chip_byte;
	logic       payload;
	logic       align;
	logic       do_write;

	assign is_prg   = byte_i.kind == KIND_PRG;
	assign is_tap   = byte_i.kind == KIND_TAP;
	assign is_crt   = byte_i.kind == KIND_CRT;
	assign ofs_zero = byte_i.offset == '0;

	assign prg_hdr     = byte_vld_i && is_prg && (byte_i.offset < 25'd2);
	assign crt_restart = byte_vld_i && is_crt && ofs_zero;
	assign chip_byte   = byte_vld_i && is_crt && (byte_i.offset >= CRT_CHIP_START);

	chip_packet_parser chip_packet_parser_i (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.crt_restart_i (crt_restart),
		.chip_byte_i   (chip_byte),
		.data_i        (byte_i.data),
		.payload_o     (payload),
		.align_o       (align),
		.bank_hdr_o    (bank_hdr_o),
		.bank_hdr_wr_o (bank_hdr_wr_o)
	);

	// TAP data starts at the base with its first byte
	assign eff_addr = (is_tap && ofs_zero) ? TAP_BASE : addr_q;

	assign do_write = byte_vld_i && ((is_prg && !prg_hdr) || is_tap || payload);

	// Round up to the next bank boundary
	assign addr_rounded = ((addr_q + load_addr_t'((1 << BANK_ALIGN_BITS) - 1))
		>> BANK_ALIGN_BITS) << BANK_ALIGN_BITS;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			addr_q      <= '0;
			wr_vld_q    <= 1'b0;
			cart_info_q <= '0;
			attached_q  <= 1'b0;
		end else begin
			wr_vld_q <= do_write;

			if (do_write)
				addr_q <= eff_addr + 1'b1;
			else if (prg_hdr && ofs_zero)
				addr_q <= load_addr_t'(byte_i.data);
			else if (prg_hdr)
				addr_q[15:8] <= byte_i.data;
			else if (crt_restart)
				addr_q <= CART_BASE;
			else if (align)
				addr_q <= addr_rounded;

			// ==============================
			// CRT file header fields
			// ==============================
			if (byte_vld_i && is_crt) begin
				if (byte_i.offset == CRT_ID_OFS)
					cart_info_q.cart_id[15:8] <= byte_i.data;
				if (byte_i.offset == CRT_ID_OFS + 1'b1)
					cart_info_q.cart_id[7:0] <= byte_i.data;
				if (byte_i.offset == CRT_EXROM_OFS)
					cart_info_q.exrom <= byte_i.data;
				if (byte_i.offset == CRT_GAME_OFS)
					cart_info_q.game <= byte_i.data;
			end

			// Cartridge detaches when a new CRT starts
			if (dl_start_i && is_crt)
				attached_q <= 1'b0;
			else if (dl_end_i && is_crt)
				attached_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_write)
			wr_q <= '{addr: eff_addr, data: byte_i.data};
	end

	assign wr_o            = wr_q;
	assign wr_vld_o        = wr_vld_q;
	assign cart_info_o     = cart_info_q;
	assign cart_attached_o = attached_q;

endmodule

//--- design/c64_image_loader_top.sv
// Image loader top level
// Joins download capture, loader core and memory write port

`timescale 1ns/10ps

module c64_image_loader_top import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  byte_t      dl_index_i,
	input  logic       dl_wr_i,
	input  dl_offset_t dl_addr_i,
	input  byte_t      dl_data_i,
	input  logic       mem_ack_i,
	output logic       dl_wait_o,
	output logic       mem_req_o,
	output mem_wr_t    mem_wr_o,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o,
	output bank_hdr_t  bank_hdr_o,
	output logic       bank_hdr_wr_o
);

	dl_byte_t dl_byte;
	logic     dl_byte_vld;
	logic     dl_start;
	logic     dl_end;
	mem_wr_t  wr;
	logic     wr_vld;
	logic     port_busy;

	dl_capture dl_capture_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.busy_i      (port_busy),
		.dl_wait_o   (dl_wait_o),
		.byte_o      (dl_byte),
		.byte_vld_o  (dl_byte_vld),
		.dl_start_o  (dl_start),
		.dl_end_o    (dl_end)
	);

	image_loader image_loader_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.byte_i          (dl_byte),
		.byte_vld_i      (dl_byte_vld),
		.dl_start_i      (dl_start),
		.dl_end_i        (dl_end),
		.wr_o            (wr),
		.wr_vld_o        (wr_vld),
		.cart_info_o     (cart_info_o),
		.cart_attached_o (cart_attached_o),
		.bank_hdr_o      (bank_hdr_o),
		.bank_hdr_wr_o   (bank_hdr_wr_o)
	);

	mem_write_port mem_write_port_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.wr_i      (wr),
		.wr_vld_i  (wr_vld),
		.mem_ack_i (mem_ack_i),
		.busy_o    (port_busy),
		.mem_req_o (mem_req_o),
		.mem_wr_o  (mem_wr_o)
	);

endmodule

//--- verif/image_loader_tests.svh
// Image loader directed tests
// Host byte drivers, typed compare tasks and one task per test

// ==============================
// Compare tasks
// ==============================
task automatic check_mem(input load_addr_t addr, input byte_t exp);
	if (!mem_image.exists(addr)) begin
		$display("No memory write was seen at address %h by %0t", addr, $time);
		other_errors++;
	end else if (mem_image[addr] !== exp) begin
		$display("Error at %0t: mem_wr_o.data @ %h expected %h, actual %h",
			$time, addr, exp, mem_image[addr]);
		value_errors++;
	end
endtask

task automatic check_cart_info(input cart_info_t exp);
	if (cart_info_o !== exp) begin
		$display("Error at %0t: cart_info_o expected %h, actual %h", $time, exp, cart_info_o);
		value_errors++;
	end
endtask

task automatic check_bank_hdr(input bank_hdr_t exp, input bank_hdr_t act);
	if (act !== exp) begin
		$display("Error at %0t: bank_hdr_o expected %h, actual %h", $time, exp, act);
		value_errors++;
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
		value_errors++;
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("Error at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
		value_errors++;
	end
endtask

// ==============================
// Host side
// ==============================
task automatic start_file(input byte_t idx);
	@(posedge clk_sys);
	dl_index_i  <= idx;
	dl_active_i <= 1'b1;
endtask

task automatic send_byte(input dl_offset_t ofs, input byte_t data);
	@(negedge clk_sys);
	while (dl_wait_o)
		@(negedge clk_sys);
	@(posedge clk_sys);
	dl_wr_i   <= 1'b1;
	dl_addr_i <= ofs;
	dl_data_i <= data;
	@(posedge clk_sys);
	dl_wr_i <= 1'b0;
endtask

task automatic end_file();
	@(negedge clk_sys);
	while (dl_wait_o)
		@(negedge clk_sys);
	@(posedge clk_sys);
	dl_active_i <= 1'b0;
	// End pulse, then the attached flag a cycle later
	repeat (3) @(posedge clk_sys);
	@(negedge clk_sys);
endtask

task automatic send_file(input byte_t idx);
	int i;
	start_file(idx);
	for (i = 0; i < file_q.size(); i++)
		send_byte(dl_offset_t'(i), file_q[i]);
	end_file();
endtask

task automatic clear_results();
	mem_image.delete();
	hdr_q.delete();
	file_q.delete();
	write_count = 0;
endtask

// CHIP packet with a big-endian header and counted payload
task automatic add_chip_packet(input bank_hdr_t hdr, input int len, input byte_t first);
	logic [31:0] pkt_len;
	int          i;
	pkt_len = 32'(len) + 32'd16;
	file_q.push_back(8'h43);
	file_q.push_back(8'h48);
	file_q.push_back(8'h49);
	file_q.push_back(8'h50);
	for (i = 3; i >= 0; i--)
		file_q.push_back(pkt_len[i*8 +: 8]);
	file_q.push_back(8'h00);
	file_q.push_back(hdr.bank_type);
	file_q.push_back(hdr.bank_num[15:8]);
	file_q.push_back(hdr.bank_num[7:0]);
	file_q.push_back(hdr.bank_laddr[15:8]);
	file_q.push_back(hdr.bank_laddr[7:0]);
	file_q.push_back(hdr.bank_size[15:8]);
	file_q.push_back(hdr.bank_size[7:0]);
	for (i = 0; i < len; i++)
		file_q.push_back(first + byte_t'(i));
endtask

// ==============================
// Directed tests
// ==============================
task automatic test_reset_state();
	@(negedge clk_sys);
	check_flag("mem_req_o", 1'b0, mem_req_o);
	check_flag("dl_wait_o", 1'b0, dl_wait_o);
	check_flag("bank_hdr_wr_o", 1'b0, bank_hdr_wr_o);
	check_flag("cart_attached_o", 1'b0, cart_attached_o);
	check_cart_info('0);
	check_bank_hdr('0, bank_hdr_o);
endtask

task automatic test_prg_load();
	int i;
	clear_results();
	file_q.push_back(8'h01);
	file_q.push_back(8'h08);
	for (i = 0; i < 20; i++)
		file_q.push_back(8'h30 + byte_t'(i));
	send_file(IDX_PRG);
	for (i = 0; i < 20; i++)
		check_mem(25'h0801 + load_addr_t'(i), file_q[i + 2]);
	check_count("PRG write count", 20, write_count);
endtask

task automatic test_tap_load();
	int i;
	clear_results();
	for (i = 0; i < 30; i++)
		file_q.push_back(8'h11 * byte_t'(i) + 8'h05);
	send_file(IDX_TAP);
	for (i = 0; i < 30; i++)
		check_mem(TAP_BASE + load_addr_t'(i), file_q[i]);
	check_count("TAP write count", 30, write_count);
endtask

task automatic test_crt_load();
	bank_hdr_t  hdr1;
	bank_hdr_t  hdr2;
	cart_info_t info;
	int         i;
	clear_results();
	hdr1 = '{bank_type: 8'h00, bank_num: 16'h0000,
	         bank_laddr: 16'h8000, bank_size: 16'h0018};
	hdr2 = '{bank_type: 8'h02, bank_num: 16'h0001,
	         bank_laddr: 16'hA000, bank_size: 16'h0008};
	info = '{cart_id: 16'h0013, exrom: 8'h01, game: 8'h80};
	for (i = 0; i < 64; i++)
		file_q.push_back(8'h00);
	// Cart id is big-endian at 0x16
	file_q[8'h16] = info.cart_id[15:8];
	file_q[8'h17] = info.cart_id[7:0];
	file_q[8'h18] = info.exrom;
	file_q[8'h19] = info.game;
	add_chip_packet(hdr1, 24, 8'hA0);
	add_chip_packet(hdr2, 8, 8'h50);
	send_file(IDX_CRT);
	check_cart_info(info);
	check_count("bank record count", 2, hdr_q.size());
	if (hdr_q.size() == 2) begin
		check_bank_hdr(hdr1, hdr_q[0]);
		check_bank_hdr(hdr2, hdr_q[1]);
	end
	for (i = 0; i < 24; i++)
		check_mem(CART_BASE + load_addr_t'(i), file_q[80 + i]);
	// Second packet lands on the next 8 KB boundary
	for (i = 0; i < 8; i++)
		check_mem(CART_BASE + 25'h2000 + load_addr_t'(i), file_q[120 + i]);
	check_count("CRT write count", 32, write_count);
	check_flag("cart_attached_o", 1'b1, cart_attached_o);
endtask

task automatic test_back_pressure();
	int i;
	clear_results();
	file_q.push_back(8'h00);
	file_q.push_back(8'hC0);
	for (i = 0; i < 64; i++)
		file_q.push_back(byte_t'($random(seed)));
	send_file(IDX_PRG);
	for (i = 0; i < 64; i++)
		check_mem(25'hC000 + load_addr_t'(i), file_q[i + 2]);
	check_count("written byte count", 64, write_count);
endtask

task automatic test_detach_reload();
	int i;
	clear_results();
	start_file(IDX_CRT_ALT);
	for (i = 0; i < 8; i++)
		send_byte(dl_offset_t'(i), 8'h00);
	@(negedge clk_sys);
	check_flag("cart_attached_o", 1'b0, cart_attached_o);
	end_file();
	file_q.push_back(8'h00);
	file_q.push_back(8'h10);
	for (i = 0; i < 10; i++)
		file_q.push_back(8'hC0 + byte_t'(i));
	send_file(IDX_PRG);
	for (i = 0; i < 10; i++)
		check_mem(25'h1000 + load_addr_t'(i), file_q[i + 2]);
	check_count("reload write count", 10, write_count);
endtask

//--- verif/tb_image_loader.sv
// Image loader testbench
// Streams PRG, TAP and CRT files into the loader and checks the memory writes

`timescale 1ns/10ps

module tb_image_loader import loader_pkg::*; ();

	localparam int CLK_HALF = 20;
	// Bytes sent over all tests for the watchdog limit
	localparam int TEST_BYTES = 266;

	logic       clk_sys;
	logic       reset_n;
	logic       dl_active_i;
	byte_t      dl_index_i;
	logic       dl_wr_i;
	dl_offset_t dl_addr_i;
	byte_t      dl_data_i;
	logic       mem_ack_i;
	logic       dl_wait_o;
	logic       mem_req_o;
	mem_wr_t    mem_wr_o;
	cart_info_t cart_info_o;
	logic       cart_attached_o;
	bank_hdr_t  bank_hdr_o;
	logic       bank_hdr_wr_o;

	integer     seed = 32'h6112_ad0e;
	int         value_errors = 0;
	int         other_errors = 0;
	int         write_count = 0;
	byte_t      file_q[$];
	bank_hdr_t  hdr_q[$];
	byte_t      mem_image[load_addr_t];

	c64_image_loader_top c64_image_loader_top_i (.*);

	initial clk_sys = 1'b0;
	always #(CLK_HALF) clk_sys = ~clk_sys;

	`include "image_loader_tests.svh"

	// ==============================
	// Memory model
	// ==============================
	initial begin : mem_responder
		int      delay;
		mem_wr_t wr;
		mem_ack_i <= 1'b0;
		forever begin
			@(negedge clk_sys);
			if (reset_n && mem_req_o) begin
				wr = mem_wr_o;
				if (mem_image.exists(wr.addr)) begin
					$display("Address %h was written twice at %0t", wr.addr, $time);
					other_errors++;
				end
				mem_image[wr.addr] = wr.data;
				write_count++;
				// Ack comes 0 to 7 cycles late
				delay = {$random(seed)} % 8;
				repeat (delay) @(posedge clk_sys);
				@(posedge clk_sys);
				mem_ack_i <= 1'b1;
				@(negedge clk_sys);
				while (mem_req_o)
					@(negedge clk_sys);
				@(posedge clk_sys);
				mem_ack_i <= 1'b0;
			end
		end
	end

	// Bank records and host wait rule
	always @(negedge clk_sys) begin
		if (bank_hdr_wr_o)
			hdr_q.push_back(bank_hdr_o);
		if (dl_wr_i && dl_wait_o) begin
			$display("Host wrote a byte while dl_wait_o was high at %0t", $time);
			other_errors++;
		end
	end

	initial begin : watchdog
		#(TEST_BYTES * 20 * 2 * CLK_HALF + 20000);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Test failed");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		$timeformat(-9, 0, " ns", 0);
		reset_n     <= 1'b0;
		dl_active_i <= 1'b0;
		dl_index_i  <= '0;
		dl_wr_i     <= 1'b0;
		dl_addr_i   <= '0;
		dl_data_i   <= '0;
		repeat (2) @(posedge clk_sys);
		reset_n <= 1'b1;

		test_reset_state();
		test_prg_load();
		test_tap_load();
		test_crt_load();
		test_back_pressure();
		test_detach_reload();

		$display("Checks complete: %0d value errors, %0d other errors",
			value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+verif
common/loader_pkg.sv
design/dl_capture.sv
design/mem_write_port.sv
loader/chip_packet_parser.sv
loader/image_loader.sv
design/c64_image_loader_top.sv
verif/tb_image_loader.sv
